/* dv/wb_soc_checker.sv */
`timescale 1ns/1ns

module wb_soc_checker (
    input logic i_clk,
    input logic i_reset,
    input logic i_a_cyc,
    input logic i_a_stb,
    input logic o_a_stall,
    input logic o_a_ack,
    input logic o_a_err,
    input logic i_b_cyc,
    input logic i_b_stb,
    input logic o_b_stall,
    input logic o_b_ack,
    input logic o_b_err
);

    ack_err_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_a_ack && o_a_err) && !(o_b_ack && o_b_err))
        else $error("ack and err high together on one master");

    // accepting edge is sampled two edges before the response
    a_response_origin: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_a_ack || o_a_err) |-> $past(i_a_stb && !o_a_stall, 2))
        else $error("master a response without an accepted strobe");

    b_response_origin: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_b_ack || o_b_err) |-> $past(i_b_stb && !o_b_stall, 2))
        else $error("master b response without an accepted strobe");

    // b cannot own the bus before its cyc was seen, so a fresh b request loses to a
    loser_stalled: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_a_cyc && i_a_stb && i_b_cyc && i_b_stb && !$past(i_b_cyc)) |-> o_b_stall)
        else $error("master b not stalled while master a requests the bus");

endmodule : wb_soc_checker

bind wb_soc_top wb_soc_checker checker_i (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_a_cyc   (i_a_cyc),
    .i_a_stb   (i_a_stb),
    .o_a_stall (o_a_stall),
    .o_a_ack   (o_a_ack),
    .o_a_err   (o_a_err),
    .i_b_cyc   (i_b_cyc),
    .i_b_stb   (i_b_stb),
    .o_b_stall (o_b_stall),
    .o_b_ack   (o_b_ack),
    .o_b_err   (o_b_err)
);

/* dv/wb_soc_tb.sv */
`timescale 1ns/1ns

`include "wb_soc_cfg.svh"

module wb_soc_tb;
    import wb_soc_pkg::*;

    // all tests together run a few hundred cycles
    localparam int MAX_CYCLES = 4000;

    logic        i_clk;
    logic        i_reset;
    logic        i_a_cyc, i_a_stb, i_a_we, o_a_stall, o_a_ack, o_a_err;
    logic        i_b_cyc, i_b_stb, i_b_we, o_b_stall, o_b_ack, o_b_err;
    wb_addr_t    i_a_addr, i_b_addr;
    wb_data_t    i_a_data, i_b_data, o_a_data, o_b_data;
    wb_sel_t     i_a_sel, i_b_sel;
    logic [15:0] i_switches;
    logic [15:0] o_leds;
    logic        o_irq;
    integer      seed;
    int          n_checks;
    int          n_errors;
    int          cycle_count;
    wb_data_t    ram_model [0:(2**`RAM_AW)-1];

    wb_soc_top dut_i (.*);

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic compare_word(input string what, input wb_data_t got, input wb_data_t exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // expected word after a write with byte selects
    function automatic wb_data_t merge_bytes(wb_data_t old, wb_data_t new_data, wb_sel_t sel);
        wb_data_t result;
        result = old;
        for (int i = 0; i < `WB_SEL_W; i++) begin
            if (sel[i]) begin
                result[8*i +: 8] = new_data[8*i +: 8];
            end
        end
        return result;
    endfunction

    task automatic drive_req(input bit use_b, input logic cyc, input logic stb, input logic we,
                             input wb_addr_t addr, input wb_data_t data, input wb_sel_t sel);
        if (use_b) begin
            i_b_cyc  <= cyc;
            i_b_stb  <= stb;
            i_b_we   <= we;
            i_b_addr <= addr;
            i_b_data <= data;
            i_b_sel  <= sel;
        end else begin
            i_a_cyc  <= cyc;
            i_a_stb  <= stb;
            i_a_we   <= we;
            i_a_addr <= addr;
            i_a_data <= data;
            i_a_sel  <= sel;
        end
    endtask

    // one access on master a or b, outputs sampled on the falling edge
    task automatic run_cycle(input bit use_b, input logic we, input wb_addr_t addr,
                             input wb_data_t data, input wb_sel_t sel, input logic exp_err,
                             output wb_data_t rdata, output int stalls);
        logic accepted;
        logic answered;
        logic err;
        int   latency;
        accepted = 1'b0;
        answered = 1'b0;
        stalls = 0;
        latency = 0;
        @(posedge i_clk);
        drive_req(use_b, 1'b1, 1'b1, we, addr, data, sel);
        // held until an edge finds stall low
        while (!accepted) begin
            @(negedge i_clk);
            accepted = use_b ? !o_b_stall : !o_a_stall;
            stalls += accepted ? 0 : 1;
            @(posedge i_clk);
        end
        drive_req(use_b, 1'b1, 1'b0, we, addr, data, sel);
        // a response seen at a falling edge is taken at the next rising edge
        while (!answered) begin
            @(negedge i_clk);
            answered = use_b ? (o_b_ack || o_b_err) : (o_a_ack || o_a_err);
            latency++;
            if (!answered) begin
                @(posedge i_clk);
            end
        end
        rdata = use_b ? o_b_data : o_a_data;
        err = use_b ? o_b_err : o_a_err;
        n_checks += 2;
        assert (latency == 2) else begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: response %0d cycles after accept", $time, latency);
        end
        assert (err == exp_err) else begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: err %b for word address %h, expected %b",
                     $time, err, addr, exp_err);
        end
        @(posedge i_clk);
        drive_req(use_b, 1'b0, 1'b0, we, addr, data, sel);
    endtask

    task automatic bus_write(input bit use_b, input wb_addr_t addr, input wb_data_t data,
                             input wb_sel_t sel);
        wb_data_t rdata;
        int       stalls;
        run_cycle(use_b, 1'b1, addr, data, sel, 1'b0, rdata, stalls);
    endtask

    task automatic bus_read(input bit use_b, input wb_addr_t addr, output wb_data_t rdata);
        int stalls;
        run_cycle(use_b, 1'b0, addr, '0, '1, 1'b0, rdata, stalls);
    endtask

    task automatic ram_readback();
        wb_addr_t addrs [8];
        wb_data_t data;
        wb_data_t got;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = wb_addr_t'($unsigned($random(seed)) % (2 ** `RAM_AW));
            data = $random(seed);
            ram_model[addrs[i]] = data;
            bus_write(i[0], addrs[i], data, '1);
        end
        for (int i = 0; i < 8; i++) begin
            bus_read(!i[0], addrs[i], got);
            compare_word("ram read back", got, ram_model[addrs[i]]);
        end
        // only lanes 0 and 2 change
        data = $random(seed);
        ram_model[addrs[0]] = merge_bytes(ram_model[addrs[0]], data, 4'b0101);
        bus_write(1'b0, addrs[0], data, 4'b0101);
        bus_read(1'b0, addrs[0], got);
        compare_word("ram byte select", got, ram_model[addrs[0]]);
    endtask

    task automatic sys_reg_access();
        wb_data_t data;
        wb_data_t got;
        wb_data_t first;
        bus_read(1'b1, `SYS_BASE, got);
        compare_word("id word", got, `SYS_ID_WORD);
        data = $random(seed);
        bus_write(1'b1, `SYS_BASE + 1, data, '1);
        bus_read(1'b0, `SYS_BASE + 1, got);
        compare_word("scratch register", got, data);
        bus_read(1'b0, `SYS_BASE + 3, first);
        repeat (10) @(posedge i_clk);
        bus_read(1'b0, `SYS_BASE + 3, got);
        n_checks++;
        assert (got > first) else begin
            n_errors++;
            $display("power counter did not advance: %h then %h", first, got);
        end
    endtask

    task automatic unmapped_error();
        wb_addr_t bad_addr;
        wb_data_t got;
        int       stalls;
        // top address bit set is far above every region
        bad_addr = {1'b1, 29'($random(seed))};
        run_cycle(1'b0, 1'b0, bad_addr, '0, '1, 1'b1, got, stalls);
        bus_read(1'b1, `SYS_BASE + 2, got);
        compare_word("bus error address", got, wb_data_t'(bad_addr) * 32'd4);
    endtask

    task automatic switch_led_port();
        wb_data_t    data;
        wb_data_t    got;
        logic [15:0] sw;
        sw = $random(seed);
        data = $random(seed);
        @(posedge i_clk);
        i_switches <= sw;
        bus_write(1'b0, `SWLED_ADDR, data, '1);
        @(negedge i_clk);
        compare_word("led outputs", wb_data_t'(o_leds), wb_data_t'(data[15:0]));
        bus_read(1'b1, `SWLED_ADDR, got);
        compare_word("switch and led read", got, {data[15:0], sw});
    endtask

    task automatic contention();
        wb_data_t got_a;
        wb_data_t got_b;
        int       stalls_a;
        int       stalls_b;
        time      done_a;
        time      done_b;
        ram_model[30'h010] = $random(seed);
        ram_model[30'h020] = $random(seed);
        bus_write(1'b0, 30'h020, ram_model[30'h020], '1);
        // both masters raise cyc and stb on the same edge
        fork
            begin
                run_cycle(1'b0, 1'b1, 30'h010, ram_model[30'h010], '1, 1'b0, got_a, stalls_a);
                done_a = $time;
            end
            begin
                run_cycle(1'b1, 1'b0, 30'h020, '0, '1, 1'b0, got_b, stalls_b);
                done_b = $time;
            end
        join
        compare_word("master b read under contention", got_b, ram_model[30'h020]);
        n_checks++;
        assert (stalls_a == 0 && stalls_b > 0 && done_a < done_b) else begin
            n_errors++;
            $display("priority broken: a stalled %0d and b stalled %0d cycles", stalls_a, stalls_b);
        end
        bus_read(1'b1, 30'h010, got_a);
        compare_word("master a write under contention", got_a, ram_model[30'h010]);
    endtask

    task automatic irq_flag();
        wb_data_t got;
        bus_write(1'b0, `SYS_BASE + 4, 32'h1, '1);
        @(negedge i_clk);
        compare_word("irq after set", wb_data_t'(o_irq), 32'h1);
        bus_read(1'b1, `SYS_BASE + 4, got);
        compare_word("irq flag register", got, 32'h1);
        bus_write(1'b1, `SYS_BASE + 4, 32'h0, '1);
        @(negedge i_clk);
        compare_word("irq after clear", wb_data_t'(o_irq), 32'h0);
    endtask

    initial begin
        seed = 32'h602a;
        i_reset <= 1'b1;
        i_switches <= '0;
        drive_req(1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        drive_req(1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        repeat (10) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        compare_word("outputs after reset",
                     wb_data_t'({o_a_ack, o_a_err, o_b_ack, o_b_err, o_irq, o_leds}), '0);
        ram_readback();
        sys_reg_access();
        unmapped_error();
        switch_led_port();
        contention();
        irq_flag();
        $display("checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : wb_soc_tb

/* include/wb_soc_cfg.svh */
`ifndef WB_SOC_CFG_SVH
`define WB_SOC_CFG_SVH

// bus geometry, addresses are word addresses
`define WB_ADDR_W 30
`define WB_DATA_W 32
`define WB_SEL_W 4

// scratch ram, 1024 words
`define RAM_AW 10
`define RAM_BASE 30'h0000000

// system register block spans 16 words
`define SYS_BASE 30'h0400000
`define SYS_AW 4

// single word for the switch/led port
`define SWLED_ADDR 30'h0400010

// identification word at sysreg 0
`define SYS_ID_WORD 32'h20191028

`endif

/* logic/wb_addr_decode.sv */
`timescale 1ns/1ns

`include "wb_soc_cfg.svh"

module wb_addr_decode (
    input  logic                i_clk,
    input  logic                i_reset,
    wb_bus_if.slave             m,
    wb_bus_if.master            ram,
    wb_bus_if.master            sys,
    wb_bus_if.master            led,
    output logic                o_bus_err,
    output wb_soc_pkg::wb_addr_t o_err_addr
);
    import wb_soc_pkg::*;

    slave_e   slave_sel;
    logic     ack_q;
    logic     none_q;
    logic     err_q;
    wb_data_t rdata_q;
    wb_addr_t err_addr_q;

    // region match on the word address
    always_comb begin
        if ((m.addr >> `RAM_AW) == (`RAM_BASE >> `RAM_AW)) begin
            slave_sel = SEL_RAM;
        end else if ((m.addr >> `SYS_AW) == (`SYS_BASE >> `SYS_AW)) begin
            slave_sel = SEL_SYS;
        end else if (m.addr == `SWLED_ADDR) begin
            slave_sel = SEL_SWLED;
        end else begin
            slave_sel = SEL_NONE;
        end
    end

    // fan the request out, stb only to the selected slave
    assign ram.cyc   = m.cyc;
    assign ram.stb   = m.stb && (slave_sel == SEL_RAM);
    assign ram.we    = m.we;
    assign ram.addr  = m.addr;
    assign ram.wdata = m.wdata;
    assign ram.sel   = m.sel;

    assign sys.cyc   = m.cyc;
    assign sys.stb   = m.stb && (slave_sel == SEL_SYS);
    assign sys.we    = m.we;
    assign sys.addr  = m.addr;
    assign sys.wdata = m.wdata;
    assign sys.sel   = m.sel;

    assign led.cyc   = m.cyc;
    assign led.stb   = m.stb && (slave_sel == SEL_SWLED);
    assign led.we    = m.we;
    assign led.addr  = m.addr;
    assign led.wdata = m.wdata;
    assign led.sel   = m.sel;

    // stall of whichever slave the address points at
    assign m.stall = ((slave_sel == SEL_RAM) && ram.stall)
                  || ((slave_sel == SEL_SYS) && sys.stall)
                  || ((slave_sel == SEL_SWLED) && led.stall);

    // unmapped strobes take two stages, same as a slave access
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ack_q  <= 1'b0;
            none_q <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            ack_q  <= ram.ack || sys.ack || led.ack;
            none_q <= m.stb && !m.stall && (slave_sel == SEL_NONE);
            err_q  <= none_q;
        end
    end

    // read data of the acknowledging slave
    always_ff @(posedge i_clk) begin
        if (ram.ack) begin
            rdata_q <= ram.rdata;
        end else if (sys.ack) begin
            rdata_q <= sys.rdata;
        end else if (led.ack) begin
            rdata_q <= led.rdata;
        end else begin
            rdata_q <= '0;
        end
    end

    // offending address, aligned with none_q
    always_ff @(posedge i_clk) begin
        if (m.stb && (slave_sel == SEL_NONE)) begin
            err_addr_q <= m.addr;
        end
    end

    assign m.ack   = ack_q;
    assign m.err   = err_q;
    assign m.rdata = rdata_q;

    assign o_bus_err  = none_q;
    assign o_err_addr = err_addr_q;

endmodule : wb_addr_decode

/* logic/wb_bus_if.sv */
`timescale 1ns/1ns

interface wb_bus_if;
    import wb_soc_pkg::*;

    // request, master to slave
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t addr;
    wb_data_t wdata;
    wb_sel_t  sel;

    // response, slave to master
    logic     stall;
    logic     ack;
    logic     err;
    wb_data_t rdata;

    modport master (
        output cyc, stb, we, addr, wdata, sel,
        input  stall, ack, err, rdata
    );

    modport slave (
        input  cyc, stb, we, addr, wdata, sel,
        output stall, ack, err, rdata
    );

    modport monitor (
        input cyc, stb, we, addr, wdata, sel, stall, ack, err, rdata
    );

endinterface : wb_bus_if

/* logic/wb_pri_arbiter.sv */
`timescale 1ns/1ns

module wb_pri_arbiter (
    input logic     i_clk,
    input logic     i_reset,
    wb_bus_if.slave  a,
    wb_bus_if.slave  b,
    wb_bus_if.master m
);

    // one when master a holds the merged bus
    logic owner_a;

    // ownership only moves between bus cycles, a wins ties
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            owner_a <= 1'b1;
        end else if (!m.cyc) begin
            owner_a <= a.cyc || !b.cyc;
        end
    end

    // request path is a plain mux on the owner
    assign m.cyc   = owner_a ? a.cyc   : b.cyc;
    assign m.stb   = owner_a ? a.stb   : b.stb;
    assign m.we    = owner_a ? a.we    : b.we;
    assign m.addr  = owner_a ? a.addr  : b.addr;
    assign m.wdata = owner_a ? a.wdata : b.wdata;
    assign m.sel   = owner_a ? a.sel   : b.sel;

    // non-owner is held off with stall
    assign a.stall = owner_a ? m.stall : 1'b1;
    assign b.stall = owner_a ? 1'b1 : m.stall;

    // responses go back to the owner only
    assign a.ack = owner_a && m.ack;
    assign a.err = owner_a && m.err;
    assign b.ack = !owner_a && m.ack;
    assign b.err = !owner_a && m.err;

    // read data is shared, qualified by ack
    assign a.rdata = m.rdata;
    assign b.rdata = m.rdata;

endmodule : wb_pri_arbiter

/* logic/wb_scratch_ram.sv */
`timescale 1ns/1ns

`include "wb_soc_cfg.svh"

module wb_scratch_ram (
    input logic     i_clk,
    wb_bus_if.slave s
);
    import wb_soc_pkg::*;

    wb_data_t           mem [0:(2**`RAM_AW)-1];
    logic [`RAM_AW-1:0] ram_idx;
    logic               ack_q;
    wb_data_t           rdata_q;

    assign ram_idx = s.addr[`RAM_AW-1:0];

    // byte lanes written only where sel is set
    always_ff @(posedge i_clk) begin
        if (s.stb && s.we) begin
            for (int i = 0; i < `WB_SEL_W; i++) begin
                if (s.sel[i]) begin
                    mem[ram_idx][8*i +: 8] <= s.wdata[8*i +: 8];
                end
            end
        end
    end

    // every access answers next cycle with the stored word
    always_ff @(posedge i_clk) begin
        ack_q   <= s.stb;
        rdata_q <= mem[ram_idx];
    end

    assign s.stall = 1'b0;
    assign s.ack   = ack_q;
    assign s.err   = 1'b0;
    assign s.rdata = rdata_q;

endmodule : wb_scratch_ram

/* logic/wb_soc_pkg.sv */
package wb_soc_pkg;

    `include "wb_soc_cfg.svh"

    // word address, data word and byte lane selects
    typedef logic [`WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [`WB_DATA_W-1:0] wb_data_t;
    typedef logic [`WB_SEL_W-1:0] wb_sel_t;

    // decoder target, SEL_NONE means unmapped
    typedef enum logic [1:0] {
        SEL_NONE,
        SEL_RAM,
        SEL_SYS,
        SEL_SWLED
    } slave_e;

endpackage : wb_soc_pkg

/* logic/wb_soc_top.sv */
`timescale 1ns/1ns

module wb_soc_top (
    input  logic                 i_clk,
    input  logic                 i_reset,
    // master a, priority port
    input  logic                 i_a_cyc,
    input  logic                 i_a_stb,
    input  logic                 i_a_we,
    input  wb_soc_pkg::wb_addr_t i_a_addr,
    input  wb_soc_pkg::wb_data_t i_a_data,
    input  wb_soc_pkg::wb_sel_t  i_a_sel,
    output logic                 o_a_stall,
    output logic                 o_a_ack,
    output logic                 o_a_err,
    output wb_soc_pkg::wb_data_t o_a_data,
    // master b, debug port
    input  logic                 i_b_cyc,
    input  logic                 i_b_stb,
    input  logic                 i_b_we,
    input  wb_soc_pkg::wb_addr_t i_b_addr,
    input  wb_soc_pkg::wb_data_t i_b_data,
    input  wb_soc_pkg::wb_sel_t  i_b_sel,
    output logic                 o_b_stall,
    output logic                 o_b_ack,
    output logic                 o_b_err,
    output wb_soc_pkg::wb_data_t o_b_data,
    input  logic [15:0]          i_switches,
    output logic [15:0]          o_leds,
    output logic                 o_irq
);
    import wb_soc_pkg::*;

    wb_bus_if a_bus ();
    wb_bus_if b_bus ();
    wb_bus_if m_bus ();
    wb_bus_if ram_bus ();
    wb_bus_if sys_bus ();
    wb_bus_if led_bus ();

    logic     bus_err;
    wb_addr_t err_addr;

    assign a_bus.cyc   = i_a_cyc;
    assign a_bus.stb   = i_a_stb;
    assign a_bus.we    = i_a_we;
    assign a_bus.addr  = i_a_addr;
    assign a_bus.wdata = i_a_data;
    assign a_bus.sel   = i_a_sel;
    assign o_a_stall   = a_bus.stall;
    assign o_a_ack     = a_bus.ack;
    assign o_a_err     = a_bus.err;
    assign o_a_data    = a_bus.rdata;

    assign b_bus.cyc   = i_b_cyc;
    assign b_bus.stb   = i_b_stb;
    assign b_bus.we    = i_b_we;
    assign b_bus.addr  = i_b_addr;
    assign b_bus.wdata = i_b_data;
    assign b_bus.sel   = i_b_sel;
    assign o_b_stall   = b_bus.stall;
    assign o_b_ack     = b_bus.ack;
    assign o_b_err     = b_bus.err;
    assign o_b_data    = b_bus.rdata;

    wb_pri_arbiter arbiter_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .a       (a_bus.slave),
        .b       (b_bus.slave),
        .m       (m_bus.master)
    );

    wb_addr_decode decode_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .m          (m_bus.slave),
        .ram        (ram_bus.master),
        .sys        (sys_bus.master),
        .led        (led_bus.master),
        .o_bus_err  (bus_err),
        .o_err_addr (err_addr)
    );

    wb_scratch_ram ram_i (
        .i_clk (i_clk),
        .s     (ram_bus.slave)
    );

    wb_sys_regs sys_regs_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .s          (sys_bus.slave),
        .i_bus_err  (bus_err),
        .i_err_addr (err_addr),
        .o_irq      (o_irq)
    );

    wb_switch_led swled_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .s          (led_bus.slave),
        .i_switches (i_switches),
        .o_leds     (o_leds)
    );

endmodule : wb_soc_top

/* logic/wb_switch_led.sv */
`timescale 1ns/1ns

module wb_switch_led (
    input  logic        i_clk,
    input  logic        i_reset,
    wb_bus_if.slave     s,
    input  logic [15:0] i_switches,
    output logic [15:0] o_leds
);
    import wb_soc_pkg::*;

    logic [15:0] leds_q;
    logic        ack_q;
    wb_data_t    rdata_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            leds_q <= '0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= s.stb;
            if (s.stb && s.we) begin
                leds_q <= s.wdata[15:0];
            end
        end
    end

    // leds in the upper half, switches in the lower
    always_ff @(posedge i_clk) begin
        rdata_q <= {leds_q, i_switches};
    end

    assign s.stall = 1'b0;
    assign s.ack   = ack_q;
    assign s.err   = 1'b0;
    assign s.rdata = rdata_q;
    assign o_leds  = leds_q;

endmodule : wb_switch_led

/* logic/wb_sys_regs.sv */
`timescale 1ns/1ns

`include "wb_soc_cfg.svh"

module wb_sys_regs (
    input  logic                 i_clk,
    input  logic                 i_reset,
    wb_bus_if.slave              s,
    input  logic                 i_bus_err,
    input  wb_soc_pkg::wb_addr_t i_err_addr,
    output logic                 o_irq
);
    import wb_soc_pkg::*;

    localparam logic [`SYS_AW-1:0] REG_ID      = 'h0;
    localparam logic [`SYS_AW-1:0] REG_SCRATCH = 'h1;
    localparam logic [`SYS_AW-1:0] REG_ERRADDR = 'h2;
    localparam logic [`SYS_AW-1:0] REG_POWER   = 'h3;
    localparam logic [`SYS_AW-1:0] REG_IRQ     = 'h4;

    logic [`SYS_AW-1:0] reg_idx;
    logic               ack_q;
    logic               irq_q;
    wb_data_t           rdata_q;
    wb_data_t           scratch_q;
    wb_data_t           power_cnt;
    wb_addr_t           err_addr_q;

    assign reg_idx = s.addr[`SYS_AW-1:0];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ack_q      <= 1'b0;
            irq_q      <= 1'b0;
            err_addr_q <= '0;
        end else begin
            ack_q <= s.stb;
            if (s.stb && s.we && (reg_idx == REG_IRQ)) begin
                irq_q <= s.wdata[0];
            end
            if (i_bus_err) begin
                err_addr_q <= i_err_addr;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (s.stb && s.we && (reg_idx == REG_SCRATCH)) begin
            scratch_q <= s.wdata;
        end
    end

    // cycles since reset, top bit sticks once reached
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            power_cnt <= '0;
        end else if (!power_cnt[`WB_DATA_W-1]) begin
            power_cnt <= power_cnt + 1'b1;
        end else begin
            power_cnt[`WB_DATA_W-2:0] <= power_cnt[`WB_DATA_W-2:0] + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        case (reg_idx)
            REG_ID:      rdata_q <= `SYS_ID_WORD;
            REG_SCRATCH: rdata_q <= scratch_q;
            REG_ERRADDR: rdata_q <= {err_addr_q, 2'b00};
            REG_POWER:   rdata_q <= power_cnt;
            REG_IRQ:     rdata_q <= wb_data_t'(irq_q);
            default:     rdata_q <= '0;
        endcase
    end

    assign s.stall = 1'b0;
    assign s.ack   = ack_q;
    assign s.err   = 1'b0;
    assign s.rdata = rdata_q;
    assign o_irq   = irq_q;

endmodule : wb_sys_regs

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
verilator --binary --timing --assert -Wno-fatal -f wb_soc.f --top-module wb_soc_tb \
    -o wb_soc_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/wb_soc_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "no pass verdict in sim.log"; exit 1; }
echo "simulation passed"

/* wb_soc.f */
+incdir+include
logic/wb_soc_pkg.sv
logic/wb_bus_if.sv
logic/wb_pri_arbiter.sv
logic/wb_addr_decode.sv
logic/wb_sys_regs.sv
logic/wb_scratch_ram.sv
logic/wb_switch_led.sv
logic/wb_soc_top.sv
dv/wb_soc_checker.sv
dv/wb_soc_tb.sv
